// ==== Bender.yml ====
package:
  name: dcmp

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dcmp_pkg.sv
      - hdl/dcmp_ctrl.sv
      - hdl/dcmp_mod_unit.sv
      - hdl/dcmp_mem_arbiter.sv
      - hdl/dcmp_mem.sv
      - hdl/dcmp_top.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/dcmp_tb.sv

// ==== dv/dcmp_tb_model.svh ====
//--------------------------------------------------------------------------
// Testbench model for the decompose engine
// LCG source, reference decomposition and typed compare tasks
//--------------------------------------------------------------------------

`ifndef DCMP_TB_MODEL_SVH
`define DCMP_TB_MODEL_SVH

logic [31:0] lcg_state;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Fold the upper bits down, the raw low bits repeat quickly
    return lcg_state ^ (lcg_state >> 15);
endfunction

//--------------------------------------------------------------------------
// Reference decomposition
//--------------------------------------------------------------------------

// Residue of r modulo 2*gamma2 in (-gamma2, gamma2]
function automatic int centered_r0(int r);
    int m;
    m = r % (2 * `DCMP_GAMMA2);
    if (m > `DCMP_GAMMA2) begin
        m = m - 2 * `DCMP_GAMMA2;
    end
    return m;
endfunction

function automatic r1_t ref_r1(coef_t c);
    int r;
    int r0;
    r  = int'(c) % `DCMP_Q;
    r0 = centered_r0(r);
    if (r - r0 == `DCMP_Q - 1) begin
        return '0;
    end
    return r1_t'((r - r0) / (2 * `DCMP_GAMMA2));
endfunction

// Low part as stored in memory, mod q
function automatic coef_t ref_r0(coef_t c);
    int r;
    int r0;
    r  = int'(c) % `DCMP_Q;
    r0 = centered_r0(r);
    if (r - r0 == `DCMP_Q - 1) begin
        r0 = r0 - 1;
    end
    if (r0 < 0) begin
        r0 = r0 + `DCMP_Q;
    end
    return coef_t'(r0);
endfunction

function automatic r1_word_t ref_r1_word(mem_word_t w);
    r1_word_t res;
    for (int i = 0; i < `DCMP_COEFS_PER_WORD; i++) begin
        res[i] = ref_r1(w[i]);
    end
    return res;
endfunction

function automatic mem_word_t ref_r0_word(mem_word_t w);
    mem_word_t res;
    for (int i = 0; i < `DCMP_COEFS_PER_WORD; i++) begin
        res[i] = ref_r0(w[i]);
    end
    return res;
endfunction

//--------------------------------------------------------------------------
// Compare tasks
//--------------------------------------------------------------------------

task automatic check_word(string name, mem_word_t exp, mem_word_t act);
    if (act !== exp) begin
        abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_r1(string name, r1_word_t exp, r1_word_t act);
    if (act !== exp) begin
        abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
        abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
endtask

`endif

// ==== dv/dcmp_tb.sv ====
//--------------------------------------------------------------------------
// Testbench for the decompose engine top level
// Host traffic, decompose runs, rejects and zeroize against a shadow model
//--------------------------------------------------------------------------

`include "dcmp_cfg.svh"

module dcmp_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dcmp_pkg::*;

    localparam int RUN_WORDS = `DCMP_POLY_WORDS;
    localparam int TIMEOUT   = 4 * RUN_WORDS + 100;

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    logic      decompose_enable;
    mem_addr_t src_base_addr;
    mem_addr_t dest_base_addr;
    mem_req_t  host_req;
    mem_word_t host_rdata;
    logic      host_rdata_valid;
    logic      host_reject;
    r1_word_t  r1_data;
    logic      r1_valid;
    logic      decompose_done;

    // Shadow of the coefficient memory and the words still expected from the engine
    mem_word_t shadow [1 << `DCMP_MEM_ADDR_WIDTH];
    r1_word_t  exp_r1_q[$];
    mem_word_t exp_r0_q[$];
    mem_addr_t exp_addr_q[$];
    int        r1_count;
    mem_addr_t src;
    mem_addr_t dst;

    `include "dcmp_tb_model.svh"

    dcmp_top uut (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .host_req         (host_req),
        .host_rdata       (host_rdata),
        .host_rdata_valid (host_rdata_valid),
        .host_reject      (host_reject),
        .r1_data          (r1_data),
        .r1_valid         (r1_valid),
        .decompose_done   (decompose_done)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each r1 word is checked in order and its r0 lands in the shadow at the same time
    always @(negedge clk) begin
        if (reset_n && r1_valid) begin
            if (exp_r1_q.size() == 0) begin
                abort_run("r1_valid asserted while no decompose word was outstanding");
            end else begin
                check_r1("r1_data", exp_r1_q.pop_front(), r1_data);
                shadow[exp_addr_q.pop_front()] = exp_r0_q.pop_front();
                r1_count++;
            end
        end
    end

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------

    function automatic mem_req_t make_req(rw_op_e op, mem_addr_t addr, mem_word_t wdata);
        mem_req_t req;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    // Mostly uniform below q with corners and values near multiples of 2*gamma2
    function automatic coef_t random_coef();
        logic [31:0] sel;
        int          v;
        sel = next_rand();
        case (sel[2:0])
            3'd0: begin
                case (sel[4:3])
                    2'd0: v = 0;
                    2'd1: v = `DCMP_GAMMA2;
                    2'd2: v = `DCMP_Q - 1;
                    default: v = `DCMP_Q - 1 - `DCMP_GAMMA2;
                endcase
            end
            3'd1, 3'd2: v = int'(sel[15:8] % 45) * 2 * `DCMP_GAMMA2 + int'(sel[18:16]) - 4;
            default: v = int'(next_rand() % `DCMP_Q);
        endcase
        if (v < 0) begin
            v = 0;
        end
        if (v > `DCMP_Q - 1) begin
            v = `DCMP_Q - 1;
        end
        return coef_t'(v);
    endfunction

    function automatic mem_word_t random_word();
        mem_word_t w;
        for (int i = 0; i < `DCMP_COEFS_PER_WORD; i++) begin
            w[i] = random_coef();
        end
        return w;
    endfunction

    task automatic host_write(mem_addr_t addr, mem_word_t w);
        @(posedge clk);
        host_req <= make_req(RW_WRITE, addr, w);
        @(posedge clk);
        host_req <= '0;
    endtask

    // Read data is due exactly one cycle after the request
    task automatic host_read_check(mem_addr_t addr, mem_word_t exp);
        @(posedge clk);
        host_req <= make_req(RW_READ, addr, '0);
        @(posedge clk);
        host_req <= '0;
        @(negedge clk);
        check_flag($sformatf("host_rdata_valid at %0h", addr), 1'b1, host_rdata_valid);
        check_word($sformatf("host read at %0h", addr), exp, host_rdata);
    endtask

    task automatic fill_region(mem_addr_t base);
        mem_word_t w;
        for (int i = 0; i < RUN_WORDS; i++) begin
            w = random_word();
            host_write(mem_addr_t'(base + i), w);
            shadow[mem_addr_t'(base + i)] = w;
        end
        for (int i = 0; i < RUN_WORDS; i++) begin
            host_read_check(mem_addr_t'(base + i), shadow[mem_addr_t'(base + i)]);
        end
    endtask

    task automatic check_region(mem_addr_t base);
        for (int i = 0; i < RUN_WORDS; i++) begin
            host_read_check(mem_addr_t'(base + i), shadow[mem_addr_t'(base + i)]);
        end
    endtask

    task automatic host_rejected(mem_req_t req);
        @(posedge clk);
        host_req <= req;
        @(negedge clk);
        check_flag("host_reject while busy", 1'b1, host_reject);
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic start_run(mem_addr_t src_a, mem_addr_t dst_a);
        for (int i = 0; i < RUN_WORDS; i++) begin
            exp_r1_q.push_back(ref_r1_word(shadow[mem_addr_t'(src_a + i)]));
            exp_r0_q.push_back(ref_r0_word(shadow[mem_addr_t'(src_a + i)]));
            exp_addr_q.push_back(mem_addr_t'(dst_a + i));
        end
        r1_count = 0;
        @(posedge clk);
        src_base_addr    <= src_a;
        dest_base_addr   <= dst_a;
        decompose_enable <= 1'b1;
        @(posedge clk);
        decompose_enable <= 1'b0;
        @(negedge clk);
        check_flag("decompose_done after start", 1'b0, decompose_done);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while ((decompose_done !== 1'b1) && (cycles < TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (decompose_done !== 1'b1) begin
            abort_run("timeout while waiting for decompose_done to rise");
        end else if (r1_count != RUN_WORDS) begin
            abort_run($sformatf("[ERROR] r1 word count: expected %0d, actual %0d",
                                RUN_WORDS, r1_count));
        end
    endtask

    // Polled on the rising edge, away from the counter updates on the falling edge
    task automatic wait_r1_count(int n);
        int cycles;
        cycles = 0;
        while ((r1_count < n) && (cycles < TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (r1_count < n) begin
            abort_run("timeout while waiting for r1 words from the engine");
        end
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------

    initial begin
        lcg_state        = 32'h20dd2bb2;
        reset_n          = 1'b0;
        zeroize          = 1'b0;
        decompose_enable = 1'b0;
        src_base_addr    = '0;
        dest_base_addr   = '0;
        host_req         = '0;
        r1_count         = 0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_flag("decompose_done after reset", 1'b1, decompose_done);
        check_flag("r1_valid after reset", 1'b0, r1_valid);
        check_flag("host_rdata_valid after reset", 1'b0, host_rdata_valid);
        check_flag("host_reject after reset", 1'b0, host_reject);

        // Source in the lower half and destination in the upper half
        src = mem_addr_t'(next_rand() % 257);
        dst = mem_addr_t'(512 + next_rand() % 257);
        fill_region(src);
        start_run(src, dst);
        for (int i = 0; i < 4; i++) begin
            host_rejected(make_req((next_rand() % 2) ? RW_READ : RW_WRITE,
                                   mem_addr_t'(src + next_rand() % RUN_WORDS),
                                   random_word()));
        end
        // Second start while busy
        @(posedge clk);
        decompose_enable <= 1'b1;
        @(posedge clk);
        decompose_enable <= 1'b0;
        wait_done();
        check_region(dst);
        check_region(src);

        // Halves swapped and the run cut short by zeroize
        src = mem_addr_t'(512 + next_rand() % 257);
        dst = mem_addr_t'(next_rand() % 257);
        fill_region(src);
        start_run(src, dst);
        wait_r1_count(RUN_WORDS / 4);
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        exp_r1_q.delete();
        exp_r0_q.delete();
        exp_addr_q.delete();
        @(negedge clk);
        check_flag("decompose_done after zeroize", 1'b1, decompose_done);
        repeat (8) @(negedge clk);

        // Fresh run on the same source
        start_run(src, dst);
        wait_done();
        check_region(dst);
        check_region(src);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
+incdir+dv
hdl/dcmp_pkg.sv
hdl/dcmp_ctrl.sv
hdl/dcmp_mod_unit.sv
hdl/dcmp_mem_arbiter.sv
hdl/dcmp_mem.sv
hdl/dcmp_top.sv
dv/dcmp_tb.sv

// ==== hdl/dcmp_cfg.svh ====
//--------------------------------------------------------------------------
// Configuration macros for the decompose engine
// Memory geometry, polynomial sizes and the modulus constants
//--------------------------------------------------------------------------

`ifndef DCMP_CFG_SVH
`define DCMP_CFG_SVH

// Word address width of the coefficient memory
`define DCMP_MEM_ADDR_WIDTH 10

// Polynomial geometry
`define DCMP_N 256
`define DCMP_K 4
`define DCMP_COEFS_PER_WORD 4

// Modulus and decomposition bound
`define DCMP_Q 8380417
`define DCMP_GAMMA2 95232

// Memory words touched by one run
`define DCMP_POLY_WORDS ((`DCMP_K * `DCMP_N) / `DCMP_COEFS_PER_WORD)

`endif

// ==== hdl/dcmp_ctrl.sv ====
//--------------------------------------------------------------------------
// Decompose controller
// Read and write FSMs with the address counters for one run
//--------------------------------------------------------------------------

`include "dcmp_cfg.svh"

module dcmp_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                decompose_enable,
    input  dcmp_pkg::mem_addr_t src_base_addr,
    input  dcmp_pkg::mem_addr_t dest_base_addr,
    input  logic                r0_valid,
    output dcmp_pkg::mem_req_t  eng_rd_req,
    output logic                mod_enable,
    output dcmp_pkg::mem_addr_t eng_wr_addr,
    output logic                eng_wr_en,
    output logic                decompose_done
);
    import dcmp_pkg::*;

    localparam mem_addr_t LAST_WORD = mem_addr_t'(`DCMP_POLY_WORDS - 1);

    dcmp_rd_state_e rd_state, rd_state_nxt;
    dcmp_wr_state_e wr_state, wr_state_nxt;

    mem_addr_t rd_addr, rd_cnt;
    mem_addr_t wr_addr, wr_cnt;
    logic      start;
    logic      rd_last;
    logic      wr_last;

    // A start strobe only counts when both FSMs are idle
    assign start   = decompose_enable && decompose_done;
    assign rd_last = (rd_state == DCMP_RD_MEM) && (rd_cnt == LAST_WORD);
    assign wr_last = r0_valid && (wr_cnt == LAST_WORD);

    //----------------------------------------------------------------------
    // Read side
    //----------------------------------------------------------------------

    always_comb begin
        case (rd_state)
            DCMP_RD_IDLE: rd_state_nxt = start ? DCMP_RD_MEM : DCMP_RD_IDLE;
            DCMP_RD_MEM:  rd_state_nxt = rd_last ? DCMP_RD_IDLE : DCMP_RD_MEM;
            default:      rd_state_nxt = DCMP_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= DCMP_RD_IDLE;
            rd_addr  <= '0;
            rd_cnt   <= '0;
        end else if (zeroize) begin
            rd_state <= DCMP_RD_IDLE;
            rd_addr  <= '0;
            rd_cnt   <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            if (start) begin
                rd_addr <= src_base_addr;
                rd_cnt  <= '0;
            end else if (rd_state == DCMP_RD_MEM) begin
                rd_addr <= rd_addr + 1'b1;
                rd_cnt  <= rd_cnt + 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Write side
    //----------------------------------------------------------------------

    // Armed together with the read FSM, steps once per r0_valid
    always_comb begin
        case (wr_state)
            DCMP_WR_IDLE: wr_state_nxt = start ? DCMP_WR_MEM : DCMP_WR_IDLE;
            DCMP_WR_MEM:  wr_state_nxt = wr_last ? DCMP_WR_IDLE : DCMP_WR_MEM;
            default:      wr_state_nxt = DCMP_WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= DCMP_WR_IDLE;
            wr_addr  <= '0;
            wr_cnt   <= '0;
        end else if (zeroize) begin
            wr_state <= DCMP_WR_IDLE;
            wr_addr  <= '0;
            wr_cnt   <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            if (start) begin
                wr_addr <= dest_base_addr;
                wr_cnt  <= '0;
            end else if (r0_valid && (wr_state == DCMP_WR_MEM)) begin
                wr_addr <= wr_addr + 1'b1;
                wr_cnt  <= wr_cnt + 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Outputs
    //----------------------------------------------------------------------

    // No new read in a zeroize cycle, so nothing reaches the pipeline after it
    assign mod_enable = (rd_state == DCMP_RD_MEM) && !zeroize;

    always_comb begin
        eng_rd_req.op    = mod_enable ? RW_READ : RW_IDLE;
        eng_rd_req.addr  = rd_addr;
        eng_rd_req.wdata = '0;
    end

    assign eng_wr_addr    = wr_addr;
    assign eng_wr_en      = r0_valid;
    assign decompose_done = (rd_state == DCMP_RD_IDLE) && (wr_state == DCMP_WR_IDLE);

    // Mod unit output only ever lands inside an armed write window
    a_wr_in_run: assert property (@(posedge clk) disable iff (!reset_n)
        eng_wr_en |-> (wr_state == DCMP_WR_MEM));

    // Start while the write side drains must not launch reads
    a_busy_start_ignored: assert property (@(posedge clk) disable iff (!reset_n)
        (decompose_enable && !decompose_done && rd_state == DCMP_RD_IDLE)
        |=> !mod_enable);

endmodule

// ==== hdl/dcmp_mem.sv ====
//--------------------------------------------------------------------------
// Coefficient memory, one read and one write port
// Registered read with one cycle of latency
//--------------------------------------------------------------------------

`include "dcmp_cfg.svh"

module dcmp_mem (
    input  logic                clk,
    input  dcmp_pkg::mem_req_t  rd_req,
    input  dcmp_pkg::mem_req_t  wr_req,
    output dcmp_pkg::mem_word_t rd_data
);
    import dcmp_pkg::*;

    localparam int DEPTH = 1 << `DCMP_MEM_ADDR_WIDTH;

    mem_word_t mem_array [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_req.op == RW_WRITE) begin
            mem_array[wr_req.addr] <= wr_req.wdata;
        end
    end

    // Same-address read and write returns the old word
    always_ff @(posedge clk) begin
        if (rd_req.op == RW_READ) begin
            rd_data <= mem_array[rd_req.addr];
        end
    end

endmodule

// ==== hdl/dcmp_mem_arbiter.sv ====
//--------------------------------------------------------------------------
// Memory arbiter between the engine and the host port
// Engine wins both ports and read data follows a one-cycle owner tag
//--------------------------------------------------------------------------

module dcmp_mem_arbiter (
    input  logic                clk,
    input  logic                reset_n,
    input  dcmp_pkg::mem_req_t  eng_rd_req,
    input  logic                eng_wr_en,
    input  dcmp_pkg::mem_addr_t eng_wr_addr,
    input  dcmp_pkg::mem_word_t eng_wr_data,
    input  dcmp_pkg::mem_req_t  host_req,
    input  logic                engine_busy,
    output dcmp_pkg::mem_req_t  mem_rd_req,
    output dcmp_pkg::mem_req_t  mem_wr_req,
    input  dcmp_pkg::mem_word_t mem_rd_data,
    output logic                eng_rd_valid,
    output dcmp_pkg::mem_word_t eng_rd_data,
    output dcmp_pkg::mem_word_t host_rdata,
    output logic                host_rdata_valid,
    output logic                host_reject
);
    import dcmp_pkg::*;

    logic eng_rd;
    logic host_rd;
    logic host_wr;
    logic eng_tag;
    logic host_tag;

    assign eng_rd      = (eng_rd_req.op == RW_READ);
    assign host_rd     = !engine_busy && (host_req.op == RW_READ) && !eng_rd;
    assign host_wr     = !engine_busy && (host_req.op == RW_WRITE) && !eng_wr_en;
    assign host_reject = engine_busy && (host_req.op != RW_IDLE);

    always_comb begin
        mem_rd_req = '0;
        mem_wr_req = '0;
        if (eng_rd) begin
            mem_rd_req = eng_rd_req;
        end else if (host_rd) begin
            mem_rd_req = host_req;
        end
        if (eng_wr_en) begin
            mem_wr_req.op    = RW_WRITE;
            mem_wr_req.addr  = eng_wr_addr;
            mem_wr_req.wdata = eng_wr_data;
        end else if (host_wr) begin
            mem_wr_req = host_req;
        end
    end

    // Who owns the data coming back next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            eng_tag  <= 1'b0;
            host_tag <= 1'b0;
        end else begin
            eng_tag  <= eng_rd;
            host_tag <= host_rd;
        end
    end

    assign eng_rd_valid     = eng_tag;
    assign eng_rd_data      = eng_tag ? mem_rd_data : '0;
    assign host_rdata_valid = host_tag;
    assign host_rdata       = host_tag ? mem_rd_data : '0;

    // Engine traffic stays inside the busy window that locks the host out
    a_rd_owner: assert property (@(posedge clk) disable iff (!reset_n)
        eng_rd |-> engine_busy);

    a_wr_owner: assert property (@(posedge clk) disable iff (!reset_n)
        eng_wr_en |-> engine_busy);

endmodule

// ==== hdl/dcmp_mod_unit.sv ====
//--------------------------------------------------------------------------
// Decompose datapath, four lanes wide
// Stage one reduces mod 2*gamma2, stage two forms r1 and stores r0 mod q
//--------------------------------------------------------------------------

`include "dcmp_cfg.svh"

module dcmp_mod_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                rd_valid,
    input  dcmp_pkg::mem_word_t rd_data,
    output logic                r0_valid,
    output dcmp_pkg::mem_word_t r0_word,
    output dcmp_pkg::r1_word_t  r1_word
);
    import dcmp_pkg::*;

    localparam int TWO_GAMMA2 = 2 * `DCMP_GAMMA2;
    // 2*gamma2 = 93 * 2^11, the low 11 bits pass straight through
    localparam int LOW_BITS    = 11;
    localparam int ODD_DIV     = TWO_GAMMA2 >> LOW_BITS;
    localparam int RECIP_SHIFT = 13;
    localparam int RECIP       = (1 << RECIP_SHIFT) / ODD_DIV;
    localparam int R1_MAX      = (`DCMP_Q - 1) / TWO_GAMMA2 - 1;

    localparam logic signed [24:0] Q_S   = `DCMP_Q;
    localparam logic signed [24:0] Q_M1  = `DCMP_Q - 1;

    logic s1_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            r0_valid <= 1'b0;
        end else if (zeroize) begin
            s1_valid <= 1'b0;
            r0_valid <= 1'b0;
        end else begin
            s1_valid <= rd_valid;
            r0_valid <= s1_valid;
        end
    end

    for (genvar i = 0; i < `DCMP_COEFS_PER_WORD; i++) begin : g_lane
        coef_t              r_in;
        logic [6:0]         hi_mod;
        logic [17:0]        r_mod;
        logic signed [18:0] r0_c;
        coef_t              s1_r;
        logic signed [18:0] s1_r0;
        logic signed [24:0] diff;
        logic [12:0]        d_hi;
        logic [18:0]        prod;
        logic [5:0]         q_est;
        logic [12:0]        rem;
        r1_t                r1_q;
        logic               corner;
        logic signed [24:0] r0_adj;
        logic signed [24:0] r0_modq;

        // Stage one: r mod 2*gamma2 via the odd factor, then centered
        assign r_in   = rd_data[i];
        assign hi_mod = 7'(r_in[22:LOW_BITS] % ODD_DIV);
        assign r_mod  = {hi_mod, r_in[LOW_BITS-1:0]};
        assign r0_c   = (r_mod > `DCMP_GAMMA2) ? 19'($signed({1'b0, r_mod}) - TWO_GAMMA2)
                                               : $signed({1'b0, r_mod});

        always_ff @(posedge clk) begin
            if (rd_valid) begin
                s1_r  <= r_in;
                s1_r0 <= r0_c;
            end
        end

        // Stage two: (r - r0) is a multiple of 2*gamma2, divide its top by 93
        assign diff   = $signed({2'b00, s1_r}) - s1_r0;
        assign d_hi   = diff[23:LOW_BITS];
        assign prod   = 19'(d_hi) * 19'(RECIP);
        assign q_est  = prod[18:RECIP_SHIFT];
        assign rem    = d_hi - 13'(q_est) * 13'(ODD_DIV);
        // Reciprocal rounds down, at most one step short
        assign r1_q   = (rem >= 13'(ODD_DIV)) ? q_est + 1'b1 : q_est;

        // r - r0 = q - 1 folds r1 to zero and pulls r0 down by one
        assign corner  = (diff == Q_M1);
        assign r0_adj  = corner ? s1_r0 - 1 : 25'(s1_r0);
        assign r0_modq = r0_adj[24] ? r0_adj + Q_S : r0_adj;

        always_ff @(posedge clk) begin
            if (s1_valid) begin
                r0_word[i] <= coef_t'(r0_modq);
                r1_word[i] <= corner ? '0 : r1_q;
            end
        end

        // Holds only if the memory words feeding the engine are below q
        a_r1_range: assert property (@(posedge clk) disable iff (!reset_n)
            r0_valid |-> (r1_word[i] <= r1_t'(R1_MAX)));
    end

endmodule

// ==== hdl/dcmp_pkg.sv ====
//--------------------------------------------------------------------------
// Shared types of the decompose engine
// Vector typedefs, FSM enums and the memory request struct
//--------------------------------------------------------------------------

`include "dcmp_cfg.svh"

package dcmp_pkg;

    // Widths that carry a meaning
    typedef logic [`DCMP_MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [22:0] coef_t;
    typedef logic [5:0] r1_t;

    // Four coefficients per memory word, lane 0 in the low bits
    typedef logic [`DCMP_COEFS_PER_WORD-1:0][22:0] mem_word_t;
    typedef logic [`DCMP_COEFS_PER_WORD-1:0][5:0] r1_word_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_op_e;

    // Request on a memory port, op doubles as the strobe
    typedef struct packed {
        rw_op_e    op;
        mem_addr_t addr;
        mem_word_t wdata;
    } mem_req_t;

    typedef enum logic {
        DCMP_RD_IDLE = 1'b0,
        DCMP_RD_MEM  = 1'b1
    } dcmp_rd_state_e;

    typedef enum logic {
        DCMP_WR_IDLE = 1'b0,
        DCMP_WR_MEM  = 1'b1
    } dcmp_wr_state_e;

endpackage

// ==== hdl/dcmp_top.sv ====
//--------------------------------------------------------------------------
// Decompose engine top level
// Controller, mod unit, arbiter and coefficient memory
//--------------------------------------------------------------------------

module dcmp_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                decompose_enable,
    input  dcmp_pkg::mem_addr_t src_base_addr,
    input  dcmp_pkg::mem_addr_t dest_base_addr,
    input  dcmp_pkg::mem_req_t  host_req,
    output dcmp_pkg::mem_word_t host_rdata,
    output logic                host_rdata_valid,
    output logic                host_reject,
    output dcmp_pkg::r1_word_t  r1_data,
    output logic                r1_valid,
    output logic                decompose_done
);
    import dcmp_pkg::*;

    mem_req_t  eng_rd_req;
    mem_addr_t eng_wr_addr;
    logic      eng_wr_en;
    mem_word_t r0_word;
    logic      eng_rd_valid;
    mem_word_t eng_rd_data;
    mem_req_t  mem_rd_req;
    mem_req_t  mem_wr_req;
    mem_word_t mem_rd_data;
    logic      engine_busy;

    assign engine_busy = !decompose_done;

    dcmp_ctrl u_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .r0_valid         (r1_valid),
        .eng_rd_req       (eng_rd_req),
        .mod_enable       (),
        .eng_wr_addr      (eng_wr_addr),
        .eng_wr_en        (eng_wr_en),
        .decompose_done   (decompose_done)
    );

    // r0 and r1 leave the pipeline together, one valid covers both
    dcmp_mod_unit u_mod_unit (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .rd_valid (eng_rd_valid),
        .rd_data  (eng_rd_data),
        .r0_valid (r1_valid),
        .r0_word  (r0_word),
        .r1_word  (r1_data)
    );

    dcmp_mem_arbiter u_arbiter (
        .clk              (clk),
        .reset_n          (reset_n),
        .eng_rd_req       (eng_rd_req),
        .eng_wr_en        (eng_wr_en),
        .eng_wr_addr      (eng_wr_addr),
        .eng_wr_data      (r0_word),
        .host_req         (host_req),
        .engine_busy      (engine_busy),
        .mem_rd_req       (mem_rd_req),
        .mem_wr_req       (mem_wr_req),
        .mem_rd_data      (mem_rd_data),
        .eng_rd_valid     (eng_rd_valid),
        .eng_rd_data      (eng_rd_data),
        .host_rdata       (host_rdata),
        .host_rdata_valid (host_rdata_valid),
        .host_reject      (host_reject)
    );

    dcmp_mem u_mem (
        .clk     (clk),
        .rd_req  (mem_rd_req),
        .wr_req  (mem_wr_req),
        .rd_data (mem_rd_data)
    );

endmodule
